//--- all.f
common/isa_pkg.sv
common/issue_pkg.sv
common/fust_if.sv
hw/issue/regfile.sv
hw/issue/fust.sv
hw/issue/issue_sched.sv
hw/issue_top.sv
tests/issue_properties.sv
tests/issue_tb.sv

//--- common/fust_if.sv
// status table to scheduler link; the table owns the rows, the scheduler only reads
// dispatch and writeback are single-cycle strobes
`timescale 1ns/10ps

interface fust_if;

    import isa_pkg::*;
    import issue_pkg::*;

    // dispatch strobe and the row it writes
    logic      dispatch_en;
    fu_e       dispatch_fu;
    fust_row_t dispatch_row;

    // writeback strobe of the completing unit
    logic      wb_en;
    fu_e       wb_fu;

    // stored rows, indexed by unit code
    fust_row_t [NROWS-1:0] rows;

    modport tbl (
        input  dispatch_en, dispatch_fu, dispatch_row, wb_en, wb_fu,
        output rows
    );

    modport sched (
        input  dispatch_en, dispatch_fu, dispatch_row, wb_en, wb_fu, rows
    );

endinterface

//--- common/isa_pkg.sv
// scalar ISA widths and unit codes
// a producer tag is always the unit code plus one, TAG_NONE means no pending producer
package isa_pkg;

    localparam int unsigned DATA_W = 32;
    localparam int unsigned REG_W  = 5;
    localparam int unsigned NREGS  = 1 << REG_W;

    typedef logic [DATA_W-1:0] data_t;
    typedef logic [REG_W-1:0]  regbits_t;

    // unit code doubles as the status table row index
    typedef enum logic [1:0] {
        FU_ALU  = 2'd0,
        FU_LDST = 2'd1,
        FU_BR   = 2'd2
    } fu_e;

    typedef enum logic [1:0] {
        TAG_NONE = 2'd0,
        TAG_ALU  = 2'd1,
        TAG_LDST = 2'd2,
        TAG_BR   = 2'd3
    } tag_e;

    // tag carried by results of the given unit
    function automatic tag_e fu_tag(fu_e fu);
        return tag_e'(fu + 2'd1);
    endfunction

endpackage

//--- common/issue_pkg.sv
// issue stage types shared by the status table, scheduler and top level
// one row per scalar unit, row index equals the unit code
package issue_pkg;

    import isa_pkg::*;

    localparam int unsigned NROWS = 3;

    typedef enum logic [1:0] {
        FUST_EMPTY = 2'd0,
        FUST_WAIT  = 2'd1,
        FUST_EX    = 2'd2
    } fust_state_e;

    // one status table row
    typedef struct packed {
        regbits_t rd;
        regbits_t rs1;
        regbits_t rs2;
        tag_e     t1;
        tag_e     t2;
    } fust_row_t;

    // record sent to execute
    typedef struct packed {
        fu_e      fu;
        regbits_t rd;
        data_t    rdat1;
        data_t    rdat2;
    } issue_t;

endpackage

//--- hw/issue/fust.sv
// functional unit status table, one row per scalar unit
// a writeback clears matching tags in every row, also in a row dispatched that same cycle
`timescale 1ns/10ps

module fust (
    input logic CLK,
    input logic nRST,
    fust_if.tbl fif
);

    import isa_pkg::*;
    import issue_pkg::*;

    fust_row_t [NROWS-1:0] rows;
    fust_row_t [NROWS-1:0] rows_next;
    tag_e                  wb_tag;

    assign wb_tag = fu_tag(fif.wb_fu);

    always_comb begin
        rows_next = rows;
        for (int i = 0; i < NROWS; i++) begin
            // dispatch overwrites the whole row
            if (fif.dispatch_en && (fif.dispatch_fu == fu_e'(i))) begin
                rows_next[i] = fif.dispatch_row;
            end
            // then the completing unit releases its consumers
            if (fif.wb_en) begin
                if (rows_next[i].t1 == wb_tag) begin
                    rows_next[i].t1 = TAG_NONE;
                end
                if (rows_next[i].t2 == wb_tag) begin
                    rows_next[i].t2 = TAG_NONE;
                end
            end
        end
    end

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            rows <= '0;
        end else begin
            rows <= rows_next;
        end
    end

    assign fif.rows = rows;

endmodule

//--- hw/issue/issue_sched.sv
// oldest-ready-first scheduler for the three status table rows
// only rows already in WAIT at the start of a cycle compete, issue is registered one cycle later
`timescale 1ns/10ps

module issue_sched #(
    parameter int unsigned AGE_W = 2
) (
    input  logic                         CLK,
    input  logic                         nRST,
    fust_if.sched                        fif,
    output isa_pkg::regbits_t            rsel1,
    output isa_pkg::regbits_t            rsel2,
    input  isa_pkg::data_t               rdat1,
    input  isa_pkg::data_t               rdat2,
    output logic [issue_pkg::NROWS-1:0]  busy,
    output issue_pkg::issue_t            issue,
    output logic                         issue_valid
);

    import isa_pkg::*;
    import issue_pkg::*;

    localparam logic [AGE_W-1:0] AGE_MAX = '1;

    fust_state_e [NROWS-1:0]            state;
    logic        [NROWS-1:0][AGE_W-1:0] age;
    logic        [NROWS-1:0]            ready;

    logic             sel_valid;
    fu_e              sel_fu;
    logic [AGE_W-1:0] sel_age;
    fust_row_t        sel_row;

    // ready means waiting with both stored tags already clear
    always_comb begin
        for (int i = 0; i < NROWS; i++) begin
            ready[i] = (state[i] == FUST_WAIT) &&
                       (fif.rows[i].t1 == TAG_NONE) &&
                       (fif.rows[i].t2 == TAG_NONE);
        end
    end

    // strict compare keeps the lowest index on equal age
    always_comb begin
        sel_valid = 1'b0;
        sel_fu    = FU_ALU;
        sel_age   = '0;
        for (int i = 0; i < NROWS; i++) begin
            if (ready[i] && (!sel_valid || (age[i] > sel_age))) begin
                sel_valid = 1'b1;
                sel_fu    = fu_e'(i);
                sel_age   = age[i];
            end
        end
    end

    assign sel_row = fif.rows[sel_fu];
    assign rsel1   = sel_row.rs1;
    assign rsel2   = sel_row.rs2;

    // row state and age
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            state <= {NROWS{FUST_EMPTY}};
            age   <= '0;
        end else begin
            for (int i = 0; i < NROWS; i++) begin
                if (fif.dispatch_en && (fif.dispatch_fu == fu_e'(i))) begin
                    // also covers a row freed by writeback in the same cycle
                    state[i] <= FUST_WAIT;
                    age[i]   <= AGE_W'(1);
                end else if (fif.wb_en && (fif.wb_fu == fu_e'(i))) begin
                    state[i] <= FUST_EMPTY;
                    age[i]   <= '0;
                end else if (sel_valid && (sel_fu == fu_e'(i))) begin
                    state[i] <= FUST_EX;
                    age[i]   <= '0;
                end else if ((state[i] == FUST_WAIT) && (age[i] != AGE_MAX)) begin
                    age[i] <= age[i] + 1'b1;
                end
            end
        end
    end

    always_comb begin
        for (int i = 0; i < NROWS; i++) begin
            busy[i] = (state[i] != FUST_EMPTY);
        end
    end

    // issue strobe
    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            issue_valid <= 1'b0;
        end else begin
            issue_valid <= sel_valid;
        end
    end

    // issue payload, only meaningful with issue_valid
    always_ff @(posedge CLK) begin
        if (sel_valid) begin
            issue.fu    <= sel_fu;
            issue.rd    <= sel_row.rd;
            issue.rdat1 <= rdat1;
            issue.rdat2 <= rdat2;
        end
    end

endmodule

//--- hw/issue/regfile.sv
// 32 x 32-bit register file, two combinational reads and one clocked write
// no write to read bypass, register 0 always reads zero
`timescale 1ns/10ps

module regfile (
    input  logic             CLK,
    input  logic             nRST,
    input  logic             wen,
    input  isa_pkg::regbits_t wsel,
    input  isa_pkg::data_t   wdata,
    input  isa_pkg::regbits_t rsel1,
    input  isa_pkg::regbits_t rsel2,
    output isa_pkg::data_t   rdat1,
    output isa_pkg::data_t   rdat2
);

    import isa_pkg::*;

    data_t regs [NREGS];

    always_ff @(posedge CLK, negedge nRST) begin
        if (!nRST) begin
            for (int i = 0; i < NREGS; i++) begin
                regs[i] <= '0;
            end
        end else if (wen && (wsel != '0)) begin
            // register 0 never takes a write
            regs[wsel] <= wdata;
        end
    end

    always_comb begin
        rdat1 = (rsel1 == '0) ? '0 : regs[rsel1];
        rdat2 = (rsel2 == '0) ? '0 : regs[rsel2];
    end

endmodule

//--- hw/issue_top.sv
// issue stage top level with plain ports
// no back-pressure: dispatch only to a free row, writeback only for a row in EX
`timescale 1ns/10ps

module issue_top #(
    parameter int unsigned AGE_W = 2
) (
    input  logic                        CLK,
    input  logic                        nRST,
    input  logic                        dispatch_en,
    input  isa_pkg::fu_e                dispatch_fu,
    input  isa_pkg::regbits_t           dispatch_rd,
    input  isa_pkg::regbits_t           dispatch_rs1,
    input  isa_pkg::regbits_t           dispatch_rs2,
    input  isa_pkg::tag_e               dispatch_t1,
    input  isa_pkg::tag_e               dispatch_t2,
    input  logic                        wb_en,
    input  isa_pkg::fu_e                wb_fu,
    input  isa_pkg::regbits_t           wb_reg,
    input  isa_pkg::data_t              wb_data,
    output logic                        issue_valid,
    output isa_pkg::fu_e                issue_fu,
    output isa_pkg::regbits_t           issue_rd,
    output isa_pkg::data_t              issue_rdat1,
    output isa_pkg::data_t              issue_rdat2,
    output logic [issue_pkg::NROWS-1:0] busy
);

    import issue_pkg::*;

    fust_if fif ();

    isa_pkg::regbits_t rsel1;
    isa_pkg::regbits_t rsel2;
    isa_pkg::data_t    rdat1;
    isa_pkg::data_t    rdat2;
    issue_t            issue;

    assign fif.dispatch_en  = dispatch_en;
    assign fif.dispatch_fu  = dispatch_fu;
    assign fif.dispatch_row = '{rd: dispatch_rd, rs1: dispatch_rs1, rs2: dispatch_rs2,
                                t1: dispatch_t1, t2: dispatch_t2};
    assign fif.wb_en        = wb_en;
    assign fif.wb_fu        = wb_fu;

    fust u_fust (
        .CLK  (CLK),
        .nRST (nRST),
        .fif  (fif)
    );

    issue_sched #(
        .AGE_W (AGE_W)
    ) u_sched (
        .CLK         (CLK),
        .nRST        (nRST),
        .fif         (fif),
        .rsel1       (rsel1),
        .rsel2       (rsel2),
        .rdat1       (rdat1),
        .rdat2       (rdat2),
        .busy        (busy),
        .issue       (issue),
        .issue_valid (issue_valid)
    );

    regfile u_rf (
        .CLK   (CLK),
        .nRST  (nRST),
        .wen   (wb_en),
        .wsel  (wb_reg),
        .wdata (wb_data),
        .rsel1 (rsel1),
        .rsel2 (rsel2),
        .rdat1 (rdat1),
        .rdat2 (rdat2)
    );

    assign issue_fu    = issue.fu;
    assign issue_rd    = issue.rd;
    assign issue_rdat1 = issue.rdat1;
    assign issue_rdat2 = issue.rdat2;

endmodule

//--- run.sh
#!/usr/bin/env bash

cd "$(dirname "$0")" || exit 1

if ! verilator --binary --timing --assert --timescale 1ns/10ps \
        --top-module issue_tb -f all.f; then
    echo "verilator build failed"
    exit 1
fi

output="$(./obj_dir/Vissue_tb)"
status=$?
printf '%s\n' "$output"

if [ "$status" -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if printf '%s\n' "$output" | grep -qxF '>>> PASS'; then
    exit 0
fi
exit 1

//--- tests/issue_properties.sv
// concurrent checks bound into issue_sched
// a row may be reused in the cycle its own writeback frees it
`timescale 1ns/10ps

module issue_properties (
    input logic                        CLK,
    input logic                        nRST,
    input logic                        issue_valid,
    input isa_pkg::fu_e                issue_fu,
    input logic [issue_pkg::NROWS-1:0] busy,
    input logic                        dispatch_en,
    input isa_pkg::fu_e                dispatch_fu,
    input logic                        wb_en,
    input isa_pkg::fu_e                wb_fu
);

    // an issued row sits in EX and cannot be picked again right away
    assert property (@(posedge CLK) disable iff (!nRST)
        (issue_valid && $past(issue_valid)) |-> (issue_fu != $past(issue_fu)))
        else $error("row issued on two consecutive cycles while still in EX");

    // dispatch only to a free row or to the row its writeback frees
    assert property (@(posedge CLK) disable iff (!nRST)
        (dispatch_en && busy[dispatch_fu]) |-> (wb_en && (wb_fu == dispatch_fu)))
        else $error("dispatch landed on a busy row");

    // first edge out of reset sees only empty rows
    assert property (@(posedge CLK) $rose(nRST) |=> !issue_valid)
        else $error("issue_valid high in the first cycle after reset");

endmodule

bind issue_sched issue_properties u_props (
    .CLK         (CLK),
    .nRST        (nRST),
    .issue_valid (issue_valid),
    .issue_fu    (issue.fu),
    .busy        (busy),
    .dispatch_en (fif.dispatch_en),
    .dispatch_fu (fif.dispatch_fu),
    .wb_en       (fif.wb_en),
    .wb_fu       (fif.wb_fu)
);

//--- tests/issue_tb.sv
// random dispatch and writeback checked against a cycle model of the issue stage
// inputs change at the rising edge, outputs are compared at the falling edge
`timescale 1ns/10ps

module issue_tb;

    import isa_pkg::*;
    import issue_pkg::*;

    localparam int AGE_W       = 2;
    localparam int RUN_CYCLES  = 2000;
    localparam int DRAIN_LIMIT = 200;

    logic             CLK;
    logic             nRST;
    logic             dispatch_en;
    fu_e              dispatch_fu;
    regbits_t         dispatch_rd;
    regbits_t         dispatch_rs1;
    regbits_t         dispatch_rs2;
    tag_e             dispatch_t1;
    tag_e             dispatch_t2;
    logic             wb_en;
    fu_e              wb_fu;
    regbits_t         wb_reg;
    data_t            wb_data;
    logic             issue_valid;
    fu_e              issue_fu;
    regbits_t         issue_rd;
    data_t            issue_rdat1;
    data_t            issue_rdat2;
    logic [NROWS-1:0] busy;

    // reference model, advanced once per rising edge
    fust_state_e      m_state [NROWS];
    logic [AGE_W-1:0] m_age [NROWS];
    fust_row_t        m_row [NROWS];
    data_t            m_regs [NREGS];
    issue_t           exp_issue;
    logic             exp_valid;

    integer seed     = 32'h058a9f15;
    int     n_issued = 0;

    issue_top #(.AGE_W(AGE_W)) DUT (.*);

    initial begin
        CLK = 1'b0;
        forever #2 CLK = ~CLK;
    end

    function automatic int rand_below(input int n);
        logic [31:0] r;
        r = $random(seed);
        return int'(r[15:0]) % n;
    endfunction

    task automatic fail_run(input string line);
        $display("%s", line);
        $display(">>> FAIL");
        $fatal(1, "stopped at the first error");
    endtask

    // one rising edge as seen from the ports of the issue stage
    task automatic model_step();
        int   sel;
        tag_e wtag;
        sel = -1;
        for (int i = 0; i < NROWS; i++) begin
            if (m_state[i] == FUST_WAIT && m_row[i].t1 == TAG_NONE &&
                m_row[i].t2 == TAG_NONE && (sel < 0 || m_age[i] > m_age[sel])) begin
                sel = i;
            end
        end
        exp_valid = (sel >= 0);
        if (exp_valid) begin
            // operands are the registers before this edge's writeback
            exp_issue = '{fu: fu_e'(sel), rd: m_row[sel].rd,
                          rdat1: m_regs[m_row[sel].rs1], rdat2: m_regs[m_row[sel].rs2]};
        end
        wtag = tag_e'(wb_fu + 2'd1);
        for (int i = 0; i < NROWS; i++) begin
            if (dispatch_en && int'(dispatch_fu) == i) begin
                m_state[i] = FUST_WAIT;
                m_age[i]   = AGE_W'(1);
                m_row[i]   = '{rd: dispatch_rd, rs1: dispatch_rs1, rs2: dispatch_rs2,
                               t1: dispatch_t1, t2: dispatch_t2};
            end else if (wb_en && int'(wb_fu) == i) begin
                m_state[i] = FUST_EMPTY;
                m_age[i]   = '0;
            end else if (sel == i) begin
                m_state[i] = FUST_EX;
                m_age[i]   = '0;
            end else if (m_state[i] == FUST_WAIT && m_age[i] != '1) begin
                m_age[i] = m_age[i] + AGE_W'(1);
            end
            if (wb_en && m_row[i].t1 == wtag) begin
                m_row[i].t1 = TAG_NONE;
            end
            if (wb_en && m_row[i].t2 == wtag) begin
                m_row[i].t2 = TAG_NONE;
            end
        end
        // register 0 stays zero in the model
        if (wb_en && wb_reg != '0) begin
            m_regs[wb_reg] = wb_data;
        end
    endtask

    // random strobes that keep to the dispatch and writeback rules
    task automatic drive_stimulus(input logic allow_dispatch);
        int        ex_rows [$];
        int        free_rows [$];
        int        busy_rows [$];
        int        wrow;
        int        drow;
        int        u;
        fust_row_t row;
        logic      do_wb;
        logic      do_disp;
        for (int i = 0; i < NROWS; i++) begin
            if (m_state[i] == FUST_EMPTY) begin
                free_rows.push_back(i);
            end else begin
                busy_rows.push_back(i);
            end
            if (m_state[i] == FUST_EX) begin
                ex_rows.push_back(i);
            end
        end
        do_wb = (ex_rows.size() > 0) && (rand_below(2) == 1);
        wrow  = do_wb ? ex_rows[rand_below(ex_rows.size())] : 0;
        if (do_wb) begin
            // the freed row may take a new instruction in the same cycle
            free_rows.push_back(wrow);
        end
        do_disp = allow_dispatch && (free_rows.size() > 0) && (rand_below(2) == 1);
        drow    = do_disp ? free_rows[rand_below(free_rows.size())] : 0;
        row.rd  = regbits_t'(rand_below(NREGS));
        row.rs1 = regbits_t'(rand_below(NREGS));
        row.rs2 = regbits_t'(rand_below(NREGS));
        row.t1  = TAG_NONE;
        row.t2  = TAG_NONE;
        // a tag names a busy unit and reads that unit's destination
        if (busy_rows.size() > 0 && rand_below(2) == 1) begin
            u       = busy_rows[rand_below(busy_rows.size())];
            row.t1  = tag_e'(2'(u + 1));
            row.rs1 = m_row[u].rd;
        end
        if (busy_rows.size() > 0 && rand_below(2) == 1) begin
            u       = busy_rows[rand_below(busy_rows.size())];
            row.t2  = tag_e'(2'(u + 1));
            row.rs2 = m_row[u].rd;
        end
        dispatch_en  <= do_disp;
        dispatch_fu  <= fu_e'(drow);
        dispatch_rd  <= row.rd;
        dispatch_rs1 <= row.rs1;
        dispatch_rs2 <= row.rs2;
        dispatch_t1  <= row.t1;
        dispatch_t2  <= row.t2;
        wb_en        <= do_wb;
        wb_fu        <= fu_e'(wrow);
        wb_reg       <= m_row[wrow].rd;
        wb_data      <= $random(seed);
    endtask

    task automatic check_outputs();
        logic [NROWS-1:0] exp_busy;
        for (int i = 0; i < NROWS; i++) begin
            exp_busy[i] = (m_state[i] != FUST_EMPTY);
        end
        assert (busy === exp_busy) else
            fail_run($sformatf("MISMATCH at %0t: busy %b, expected %b", $time, busy, exp_busy));
        assert (issue_valid === exp_valid) else
            fail_run($sformatf("MISMATCH at %0t: issue_valid %b, expected %b",
                               $time, issue_valid, exp_valid));
        if (exp_valid) begin
            n_issued++;
            assert ({issue_fu, issue_rd, issue_rdat1, issue_rdat2} === exp_issue) else
                fail_run($sformatf("MISMATCH at %0t: issue %h, expected %h", $time,
                                   {issue_fu, issue_rd, issue_rdat1, issue_rdat2}, exp_issue));
        end
    endtask

    task automatic run_cycle(input logic allow_dispatch);
        @(posedge CLK);
        model_step();
        drive_stimulus(allow_dispatch);
        @(negedge CLK);
        check_outputs();
    endtask

    initial begin
        int drain;
        nRST         = 1'b0;
        dispatch_en  = 1'b0;
        dispatch_fu  = FU_ALU;
        dispatch_rd  = '0;
        dispatch_rs1 = '0;
        dispatch_rs2 = '0;
        dispatch_t1  = TAG_NONE;
        dispatch_t2  = TAG_NONE;
        wb_en        = 1'b0;
        wb_fu        = FU_ALU;
        wb_reg       = '0;
        wb_data      = '0;
        for (int i = 0; i < NROWS; i++) begin
            m_state[i] = FUST_EMPTY;
            m_age[i]   = '0;
            m_row[i]   = '0;
        end
        for (int i = 0; i < NREGS; i++) begin
            m_regs[i] = '0;
        end
        exp_valid = 1'b0;
        exp_issue = '0;
        repeat (2) @(posedge CLK);
        nRST <= 1'b1;
        @(negedge CLK);
        check_outputs();
        for (int c = 0; c < RUN_CYCLES; c++) begin
            run_cycle(1'b1);
        end
        // no new work, every row has to finish
        drain = 0;
        while (busy != '0) begin
            run_cycle(1'b0);
            drain++;
            assert (drain <= DRAIN_LIMIT) else
                fail_run("timeout: rows still busy long after dispatch stopped");
        end
        assert (n_issued > RUN_CYCLES / 10) else
            fail_run("too few instructions issued during the random run");
        $display(">>> PASS");
        $finish;
    end

endmodule
